//--- Bender.yml
package:
  name: slm_ctrl

sources:
  - include_dirs:
      - hw
    files:
      - hw/slm_ctrl_pkg.sv
      - hw/uart_rx.sv
      - hw/uart_tx.sv
      - hw/spi_master.sv
      - hw/cmd_pair_decoder.sv
      - hw/reply_queue.sv
      - hw/slm_ctrl_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_slm_ctrl_top.sv

//--- hw/cmd_pair_decoder.sv
// Pairs UART bytes into address and data and launches one SPI write per pair
`timescale 1ns/100ps
`default_nettype none

module cmd_pair_decoder (
  input  logic                    fpga_clk,
  input  logic                    reset_all_cmd_w,
  input  logic                    rx_valid_i,
  input  slm_ctrl_pkg::byte_t     rx_byte_i,
  output logic                    spi_start_o,
  output slm_ctrl_pkg::spi_word_t spi_word_o
);

  slm_ctrl_pkg::byte_t addr_q;
  slm_ctrl_pkg::byte_t data_q;
  // 0 means next byte is an address
  logic                odd_q;

  // phase and launch strobe
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      odd_q       <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      spi_start_o <= 1'b0;
      if (rx_valid_i) begin
        odd_q <= ~odd_q;
        // second byte of a pair completes the frame
        if (odd_q) begin
          spi_start_o <= 1'b1;
        end
      end
    end
  end

  // byte chain
  // new byte enters as data, old data moves up to address
  always_ff @(posedge fpga_clk) begin
    if (rx_valid_i) begin
      addr_q <= data_q;
      data_q <= rx_byte_i;
    end
  end

  // address goes out first on the wire
  assign spi_word_o = {addr_q, data_q};

endmodule

`default_nettype wire

//--- hw/reply_queue.sv
// Byte FIFO that buffers SPI replies and feeds the UART transmitter
`timescale 1ns/100ps
`default_nettype none
`include "slm_ctrl_consts.svh"

module reply_queue #(
  parameter int unsigned DEPTH = `REPLY_DEPTH
) (
  input  logic                fpga_clk,
  input  logic                reset_all_cmd_w,
  input  logic                reply_valid_i,
  input  slm_ctrl_pkg::byte_t reply_byte_i,
  input  logic                tx_active_i,
  output logic                tx_start_o,
  output slm_ctrl_pkg::byte_t tx_byte_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  slm_ctrl_pkg::byte_t mem_q [DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    count_q;
  logic                full;
  logic                empty;
  logic                wr_en;
  logic                rd_en;

  assign full  = (count_q == CNT_W'(DEPTH));
  assign empty = (count_q == '0);

  // reply lost when full
  assign wr_en = reply_valid_i && !full;
  // tx_start_o high means a start is still on its way to the UART
  assign rd_en = !empty && !tx_active_i && !tx_start_o;

  ////////////////////
  // pointers and count
  ////////////////////

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      tx_start_o <= 1'b0;
    end else begin
      // start follows the read by one cycle
      tx_start_o <= rd_en;
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous read and write leaves count alone
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge fpga_clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= reply_byte_i;
    end
    // read data settles with tx_start_o
    if (rd_en) begin
      tx_byte_o <= mem_q[rd_ptr_q];
    end
  end

endmodule

`default_nettype wire

//--- hw/slm_ctrl_consts.svh
// Timing and sizing constants for the SLM carrier control path
`ifndef SLM_CTRL_CONSTS_SVH
`define SLM_CTRL_CONSTS_SVH

// fpga_clk cycles per UART bit
// 62.5 MHz / 3.125 Mbaud gives an exact 20
`define CLKS_PER_BIT 20

// fpga_clk cycles per SCK half-period
// one SPI bit is twice this
`define SPI_HALF_PERIOD 2

// cycles the display reset stays low
// counted from the fall of the board reset
// display needs 100 ns minimum, 10 cycles leaves headroom
`define RESET_HOLD 10

// entries in the SPI reply FIFO
// replies beyond this while the UART is busy are lost
`define REPLY_DEPTH 4

`endif

//--- hw/slm_ctrl_pkg.sv
// Shared types of the SLM control path: byte and SPI word vectors and FSM states
`default_nettype none

package slm_ctrl_pkg;

  // one UART byte, also one SPI address or data byte
  typedef logic [7:0] byte_t;

  // one SPI frame
  // address in [15:8], data in [7:0]
  typedef logic [15:0] spi_word_t;

  // receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_e;

  // transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_e;

  // SPI master FSM
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_FINISH
  } spi_state_e;

endpackage

`default_nettype wire

//--- hw/slm_ctrl_top.sv
// Top of the SLM control path with display reset stretcher and block wiring
`timescale 1ns/100ps
`default_nettype none
`include "slm_ctrl_consts.svh"

module slm_ctrl_top (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_sdat_o,
  input  logic spi_sout_i,
  output logic slm_reset_n_o
);

  localparam int unsigned HOLD_W = $clog2(`RESET_HOLD + 1);

  logic                    rx_valid;
  slm_ctrl_pkg::byte_t     rx_byte;
  logic                    spi_start;
  slm_ctrl_pkg::spi_word_t spi_word;
  logic                    reply_valid;
  slm_ctrl_pkg::byte_t     reply_byte;
  logic                    tx_active;
  logic                    tx_start;
  slm_ctrl_pkg::byte_t     tx_byte;
  logic [HOLD_W-1:0]       hold_cnt_q;

  ////////////////////
  // display reset
  ////////////////////

  // reloads for as long as board reset is high
  // counts down to zero once it drops
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt_q <= HOLD_W'(`RESET_HOLD);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // active low, released at zero
  assign slm_reset_n_o = (hold_cnt_q == '0);

  ////////////////////
  // host to display
  ////////////////////

  uart_rx #(
    .CLKS_PER_BIT(`CLKS_PER_BIT)
  ) i_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  cmd_pair_decoder i_cmd_pair_decoder (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi_start_o     (spi_start),
    .spi_word_o      (spi_word)
  );

  spi_master i_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_start_i     (spi_start),
    .spi_word_i      (spi_word),
    .sen_o           (spi_sen_o),
    .sck_o           (spi_sck_o),
    .mosi_o          (spi_sdat_o),
    .miso_i          (spi_sout_i),
    .reply_valid_o   (reply_valid),
    .reply_byte_o    (reply_byte)
  );

  ////////////////////
  // replies to host
  ////////////////////

  reply_queue #(
    .DEPTH(`REPLY_DEPTH)
  ) i_reply_queue (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .reply_valid_i   (reply_valid),
    .reply_byte_i    (reply_byte),
    .tx_active_i     (tx_active),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx #(
    .CLKS_PER_BIT(`CLKS_PER_BIT)
  ) i_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .tx_active_o     (tx_active),
    .tx_serial_o     (uart_tx_o)
  );

endmodule

`default_nettype wire

//--- hw/spi_master.sv
// SPI master for 16-bit mode-0 writes that captures the returned low byte
`timescale 1ns/100ps
`default_nettype none
`include "slm_ctrl_consts.svh"

module spi_master (
  input  logic                    fpga_clk,
  input  logic                    reset_all_cmd_w,
  input  logic                    spi_start_i,
  input  slm_ctrl_pkg::spi_word_t spi_word_i,
  output logic                    sen_o,
  output logic                    sck_o,
  output logic                    mosi_o,
  input  logic                    miso_i,
  output logic                    reply_valid_o,
  output slm_ctrl_pkg::byte_t     reply_byte_o
);

  localparam int unsigned HALF  = `SPI_HALF_PERIOD;
  localparam int unsigned DIV_W = $clog2(HALF + 1);
  localparam logic [DIV_W-1:0] DIV_END = DIV_W'(HALF - 1);

  slm_ctrl_pkg::spi_state_e state_q;
  slm_ctrl_pkg::spi_word_t  tx_shift_q;
  logic [DIV_W-1:0]         div_q;
  logic [3:0]               bit_cnt_q;
  logic                     half_end;
  logic                     sck_rise;
  logic                     sck_fall;
  logic                     launch;

  ////////////////////
  // edge timing
  ////////////////////

  // start is dropped while a frame runs
  assign launch   = (state_q == slm_ctrl_pkg::SPI_IDLE) && spi_start_i;
  assign half_end = (state_q == slm_ctrl_pkg::SPI_SHIFT) && (div_q == DIV_END);
  // sck low at half end means it goes high next
  assign sck_rise = half_end && !sck_o;
  assign sck_fall = half_end && sck_o;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q       <= slm_ctrl_pkg::SPI_IDLE;
      div_q         <= '0;
      bit_cnt_q     <= '0;
      sen_o         <= 1'b1;
      sck_o         <= 1'b0;
      mosi_o        <= 1'b0;
      reply_valid_o <= 1'b0;
    end else begin
      reply_valid_o <= 1'b0;
      case (state_q)
        slm_ctrl_pkg::SPI_IDLE: begin
          div_q     <= '0;
          bit_cnt_q <= '0;
          if (launch) begin
            // MSB set up before the first rising edge
            sen_o   <= 1'b0;
            mosi_o  <= spi_word_i[15];
            state_q <= slm_ctrl_pkg::SPI_SHIFT;
          end
        end
        slm_ctrl_pkg::SPI_SHIFT: begin
          if (half_end) begin
            div_q <= '0;
            sck_o <= ~sck_o;
          end else begin
            div_q <= div_q + 1'b1;
          end
          // mode 0, MOSI moves on falling SCK
          if (sck_fall) begin
            mosi_o    <= tx_shift_q[15];
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 4'd15) begin
              state_q <= slm_ctrl_pkg::SPI_FINISH;
            end
          end
        end
        slm_ctrl_pkg::SPI_FINISH: begin
          // deselect and hand over the reply together
          sen_o         <= 1'b1;
          reply_valid_o <= 1'b1;
          state_q       <= slm_ctrl_pkg::SPI_IDLE;
        end
        default: state_q <= slm_ctrl_pkg::SPI_IDLE;
      endcase
    end
  end

  ////////////////////
  // data shifters
  ////////////////////

  // bits still to send, MSB first
  // bit 15 already on MOSI after launch
  always_ff @(posedge fpga_clk) begin
    if (launch) begin
      tx_shift_q <= {spi_word_i[14:0], 1'b0};
    end else if (sck_fall) begin
      tx_shift_q <= {tx_shift_q[14:0], 1'b0};
    end
  end

  // MISO sampled with each rising SCK
  // last eight samples are the data phase
  always_ff @(posedge fpga_clk) begin
    if (sck_rise) begin
      reply_byte_o <= {reply_byte_o[6:0], miso_i};
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
// UART receiver that samples the host line and pulses each received byte
`timescale 1ns/100ps
`default_nettype none
`include "slm_ctrl_consts.svh"

module uart_rx #(
  parameter int unsigned CLKS_PER_BIT = `CLKS_PER_BIT
) (
  input  logic                fpga_clk,
  input  logic                reset_all_cmd_w,
  input  logic                rx_serial_i,
  output logic                rx_valid_o,
  output slm_ctrl_pkg::byte_t rx_byte_o
);

  localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] MID_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);

  slm_ctrl_pkg::uart_rx_state_e state_q;
  logic             rx_meta_q;
  logic             rx_sync_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_idx_q;

  // host line is async to fpga_clk
  // two flops, idle level high
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= slm_ctrl_pkg::RX_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      // strobe, high for one cycle only
      rx_valid_o <= 1'b0;
      case (state_q)
        slm_ctrl_pkg::RX_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          // falling edge of start bit
          if (!rx_sync_q) begin
            state_q <= slm_ctrl_pkg::RX_START;
          end
        end
        slm_ctrl_pkg::RX_START: begin
          if (clk_cnt_q == MID_BIT) begin
            clk_cnt_q <= '0;
            // still low at mid-bit, else a glitch
            if (!rx_sync_q) begin
              state_q <= slm_ctrl_pkg::RX_DATA;
            end else begin
              state_q <= slm_ctrl_pkg::RX_IDLE;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        slm_ctrl_pkg::RX_DATA: begin
          // from here on each full bit period lands on a bit middle
          if (clk_cnt_q == BIT_END) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= slm_ctrl_pkg::RX_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        slm_ctrl_pkg::RX_STOP: begin
          if (clk_cnt_q == BIT_END) begin
            clk_cnt_q <= '0;
            // framing error drops the byte
            rx_valid_o <= rx_sync_q;
            state_q    <= slm_ctrl_pkg::RX_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= slm_ctrl_pkg::RX_IDLE;
      endcase
    end
  end

  // data bits arrive LSB first
  // shift in from the top, byte complete after eight
  always_ff @(posedge fpga_clk) begin
    if (state_q == slm_ctrl_pkg::RX_DATA && clk_cnt_q == BIT_END) begin
      rx_byte_o <= {rx_sync_q, rx_byte_o[7:1]};
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
// UART transmitter that frames one byte with start and stop bits
`timescale 1ns/100ps
`default_nettype none
`include "slm_ctrl_consts.svh"

module uart_tx #(
  parameter int unsigned CLKS_PER_BIT = `CLKS_PER_BIT
) (
  input  logic                fpga_clk,
  input  logic                reset_all_cmd_w,
  input  logic                tx_start_i,
  input  slm_ctrl_pkg::byte_t tx_byte_i,
  output logic                tx_active_o,
  output logic                tx_serial_o
);

  localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

  slm_ctrl_pkg::uart_tx_state_e state_q;
  slm_ctrl_pkg::byte_t          tx_shift_q;
  logic [CNT_W-1:0]             clk_cnt_q;
  logic [2:0]                   bit_idx_q;
  logic                         bit_end;

  assign bit_end = (clk_cnt_q == BIT_END);

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q     <= slm_ctrl_pkg::TX_IDLE;
      clk_cnt_q   <= '0;
      bit_idx_q   <= '0;
      tx_active_o <= 1'b0;
      // line idles high
      tx_serial_o <= 1'b1;
    end else begin
      case (state_q)
        slm_ctrl_pkg::TX_IDLE: begin
          clk_cnt_q   <= '0;
          bit_idx_q   <= '0;
          tx_serial_o <= 1'b1;
          if (tx_start_i) begin
            // start bit goes out right away
            tx_serial_o <= 1'b0;
            tx_active_o <= 1'b1;
            state_q     <= slm_ctrl_pkg::TX_START;
          end
        end
        slm_ctrl_pkg::TX_START: begin
          if (bit_end) begin
            clk_cnt_q   <= '0;
            tx_serial_o <= tx_shift_q[0];
            state_q     <= slm_ctrl_pkg::TX_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        slm_ctrl_pkg::TX_DATA: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              // stop bit
              tx_serial_o <= 1'b1;
              state_q     <= slm_ctrl_pkg::TX_STOP;
            end else begin
              // next bit, shift reg moves on the same edge
              tx_serial_o <= tx_shift_q[1];
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        slm_ctrl_pkg::TX_STOP: begin
          if (bit_end) begin
            clk_cnt_q   <= '0;
            tx_active_o <= 1'b0;
            state_q     <= slm_ctrl_pkg::TX_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= slm_ctrl_pkg::TX_IDLE;
      endcase
    end
  end

  // latch on start, then LSB first
  always_ff @(posedge fpga_clk) begin
    if (state_q == slm_ctrl_pkg::TX_IDLE && tx_start_i) begin
      tx_shift_q <= tx_byte_i;
    end else if (state_q == slm_ctrl_pkg::TX_DATA && bit_end) begin
      tx_shift_q <= {1'b0, tx_shift_q[7:1]};
    end
  end

endmodule

`default_nettype wire

//--- slm_ctrl_top.f
+incdir+hw
hw/slm_ctrl_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/spi_master.sv
hw/cmd_pair_decoder.sv
hw/reply_queue.sv
hw/slm_ctrl_top.sv
tb/tb_slm_ctrl_top.sv

//--- tb/tb_slm_ctrl_top.sv
// Directed testbench for the SLM control path with UART host, UART monitor and SPI slave
`timescale 1ns/100ps
`default_nettype none
`include "slm_ctrl_consts.svh"

module tb_slm_ctrl_top;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int WAIT_LIMIT     = 1000;

  logic fpga_clk;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic uart_tx_o;
  logic spi_sen_o;
  logic spi_sck_o;
  logic spi_sdat_o;
  logic spi_sout_i;
  logic slm_reset_n_o;

  int                      err_cnt;
  int                      cycle_cnt;
  logic [31:0]             lcg_state;
  slm_ctrl_pkg::spi_word_t frames_q [$];
  slm_ctrl_pkg::byte_t     replies_q [$];
  // spi slave model state
  logic                    sen_prev;
  logic                    sck_prev;
  int                      slave_bits;
  slm_ctrl_pkg::spi_word_t slave_word;
  slm_ctrl_pkg::byte_t     slave_addr;
  // uart monitor state
  slm_ctrl_pkg::byte_t     mon_byte;
  int                      mon_idx;

  slm_ctrl_top i_slm_ctrl_top (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .uart_tx_o       (uart_tx_o),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_sdat_o      (spi_sdat_o),
    .spi_sout_i      (spi_sout_i),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  // 25 MHz
  initial begin
    fpga_clk = 1'b0;
    forever #20 fpga_clk = ~fpga_clk;
  end

  // run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge fpga_clk);
      cycle_cnt++;
    end
    $display("Timeout: run stopped after %0d cycles", cycle_cnt);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////
  // bus models
  ////////////////////

  // spi slave model
  // samples on rising sck and answers with the inverted address
  initial begin
    sen_prev   = 1'b1;
    sck_prev   = 1'b0;
    slave_bits = 0;
    forever begin
      @(negedge fpga_clk);
      if (spi_sen_o) begin
        // sen rising ends a frame
        if (!sen_prev) begin
          frames_q.push_back(slave_word);
          if (slave_bits != 16) begin
            err_cnt++;
            $display("SPI frame had %0d clocks instead of 16 at %0t", slave_bits, $time);
          end
        end
        slave_bits = 0;
      end else if (spi_sck_o && !sck_prev) begin
        slave_word = {slave_word[14:0], spi_sdat_o};
        slave_bits++;
        if (slave_bits == 8) begin
          slave_addr = slave_word[7:0];
        end
      end else if (!spi_sck_o && sck_prev && slave_bits >= 8 && slave_bits < 16) begin
        // data phase goes out msb first
        spi_sout_i = ~slave_addr[15 - slave_bits];
      end
      sen_prev = spi_sen_o;
      sck_prev = spi_sck_o;
    end
  end

  // uart monitor on the reply line
  // each bit sampled at its middle
  initial begin
    forever begin
      @(negedge fpga_clk);
      if (uart_tx_o === 1'b0) begin
        repeat (`CLKS_PER_BIT / 2) @(negedge fpga_clk);
        for (mon_idx = 0; mon_idx < 8; mon_idx++) begin
          repeat (`CLKS_PER_BIT) @(negedge fpga_clk);
          mon_byte[mon_idx] = uart_tx_o;
        end
        repeat (`CLKS_PER_BIT) @(negedge fpga_clk);
        if (uart_tx_o !== 1'b1) begin
          err_cnt++;
          $display("UART reply frame has a low stop bit at %0t", $time);
        end
        replies_q.push_back(mon_byte);
      end
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_byte(input string name, input slm_ctrl_pkg::byte_t got,
                            input slm_ctrl_pkg::byte_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("** Error: %s = 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_word(input string name, input slm_ctrl_pkg::spi_word_t got,
                            input slm_ctrl_pkg::spi_word_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("** Error: %s = 0x%04h, expected 0x%04h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      err_cnt++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // host side uart sends lsb first
  // caller sits on a falling edge
  task automatic send_byte(input slm_ctrl_pkg::byte_t b);
    int i;
    uart_rx_i = 1'b0;
    repeat (`CLKS_PER_BIT) @(negedge fpga_clk);
    for (i = 0; i < 8; i++) begin
      uart_rx_i = b[i];
      repeat (`CLKS_PER_BIT) @(negedge fpga_clk);
    end
    uart_rx_i = 1'b1;
    repeat (`CLKS_PER_BIT) @(negedge fpga_clk);
  endtask

  task automatic apply_reset();
    reset_all_cmd_w = 1'b1;
    repeat (10) begin
      @(negedge fpga_clk);
      check_level("spi_sen_o", spi_sen_o, 1'b1);
      check_level("spi_sck_o", spi_sck_o, 1'b0);
      check_level("uart_tx_o", uart_tx_o, 1'b1);
      check_level("slm_reset_n_o", slm_reset_n_o, 1'b0);
    end
    reset_all_cmd_w = 1'b0;
  endtask

  task automatic check_frame(input slm_ctrl_pkg::spi_word_t exp);
    int waited;
    waited = 0;
    while (frames_q.size() == 0 && waited < WAIT_LIMIT) begin
      @(negedge fpga_clk);
      waited++;
    end
    if (frames_q.size() == 0) begin
      err_cnt++;
      $display("No SPI frame within %0d cycles at %0t", WAIT_LIMIT, $time);
    end else begin
      check_word("spi_sdat_o frame", frames_q.pop_front(), exp);
    end
  endtask

  task automatic check_reply(input slm_ctrl_pkg::byte_t exp);
    int waited;
    waited = 0;
    while (replies_q.size() == 0 && waited < WAIT_LIMIT) begin
      @(negedge fpga_clk);
      waited++;
    end
    if (replies_q.size() == 0) begin
      err_cnt++;
      $display("No UART reply within %0d cycles at %0t", WAIT_LIMIT, $time);
    end else begin
      check_byte("uart_tx_o reply", replies_q.pop_front(), exp);
    end
  endtask

  // nothing extra may show up on either bus
  task automatic check_quiet(input int window);
    repeat (window) @(negedge fpga_clk);
    check_count("extra spi frames", frames_q.size(), 0);
    check_count("extra uart replies", replies_q.size(), 0);
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_reset();
    int low_cycles;
    apply_reset();
    low_cycles = 0;
    while (slm_reset_n_o === 1'b0 && low_cycles < 100) begin
      @(negedge fpga_clk);
      low_cycles++;
    end
    check_count("slm_reset_n_o low cycles", low_cycles, `RESET_HOLD);
    check_level("spi_sen_o", spi_sen_o, 1'b1);
    check_level("spi_sck_o", spi_sck_o, 1'b0);
    check_level("uart_tx_o", uart_tx_o, 1'b1);
  endtask

  // one pair gives one frame and exactly one reply
  task automatic test_single_write();
    send_byte(8'h5a);
    send_byte(8'hc3);
    check_frame(16'h5ac3);
    check_reply(~8'h5a);
    check_quiet(400);
  endtask

  task automatic test_pairing();
    send_byte(8'h81);
    check_quiet(1000);
    send_byte(8'h7e);
    check_frame(16'h817e);
    check_reply(~8'h81);
  endtask

  // half pair before reset is forgotten
  task automatic test_reset_realign();
    send_byte(8'hf0);
    apply_reset();
    send_byte(8'h12);
    send_byte(8'h34);
    check_frame(16'h1234);
    check_reply(~8'h12);
    check_quiet(400);
  endtask

  task automatic test_stream();
    slm_ctrl_pkg::byte_t addrs [8];
    slm_ctrl_pkg::byte_t datas [8];
    logic [31:0]         rnd;
    int                  i;
    for (i = 0; i < 8; i++) begin
      rnd      = lcg_next();
      addrs[i] = rnd[23:16];
      datas[i] = rnd[15:8];
      send_byte(addrs[i]);
      send_byte(datas[i]);
    end
    for (i = 0; i < 8; i++) begin
      check_frame({addrs[i], datas[i]});
    end
    for (i = 0; i < 8; i++) begin
      check_reply(~addrs[i]);
    end
    check_quiet(400);
  endtask

  initial begin
    err_cnt         = 0;
    lcg_state       = 32'h4288_6e66;
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    spi_sout_i      = 1'b0;
    test_reset();
    test_single_write();
    test_pairing();
    test_reset_realign();
    test_stream();
    $display("Run complete: %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
